// File: logic/nes_bus_pkg.sv
package nes_bus_pkg;

    // CPU bus widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Region codes from the address decoder
    typedef logic [1:0] region_t;

    localparam region_t region_ram  = 2'd0;
    localparam region_t region_ppu  = 2'd1;
    localparam region_t region_ctlr = 2'd2;
    localparam region_t region_none = 2'd3;

    // Picture-processor register selects, codes 0 to 7 follow address bits 2:0
    typedef logic [3:0] ppu_sel_t;

    localparam ppu_sel_t ppu_ctrl   = 4'd0;
    localparam ppu_sel_t ppu_mask   = 4'd1;
    localparam ppu_sel_t ppu_status = 4'd2;
    localparam ppu_sel_t oam_addr   = 4'd3;
    localparam ppu_sel_t oam_data   = 4'd4;
    localparam ppu_sel_t ppu_scroll = 4'd5;
    localparam ppu_sel_t ppu_addr   = 4'd6;
    localparam ppu_sel_t ppu_data   = 4'd7;
    // Sprite DMA, write only
    localparam ppu_sel_t oam_dma    = 4'd8;

    // Sprite DMA register address
    localparam addr_t oam_dma_addr = 16'h4014;

    // Serial pad ports
    localparam addr_t ctlr_port1_addr = 16'h4016;
    localparam addr_t ctlr_port2_addr = 16'h4017;

endpackage : nes_bus_pkg

// File: logic/wb_cpu_port.sv
module wb_cpu_port (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  nes_bus_pkg::addr_t  adr,
    input  nes_bus_pkg::data_t  dat_w,
    output nes_bus_pkg::data_t  dat_r,
    output logic                ack,
    output logic                access,
    output nes_bus_pkg::addr_t  acc_addr,
    output logic                acc_we,
    output nes_bus_pkg::data_t  acc_wdata,
    input  nes_bus_pkg::region_t region,
    input  nes_bus_pkg::data_t  ram_rdata,
    input  nes_bus_pkg::data_t  ppu_data,
    input  nes_bus_pkg::data_t  ctlr_data
);

    import nes_bus_pkg::*;

    region_t rd_region;
    data_t   rd_hold;

    // One access per bus cycle, the cycle before ack
    assign access    = cyc && stb && !ack;
    assign acc_addr  = adr;
    assign acc_we    = we;
    assign acc_wdata = dat_w;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ack       <= 1'b0;
            rd_region <= region_none;
            rd_hold   <= '0;
        end else begin
            ack <= access;
            if (access) begin
                rd_region <= we ? region_none : region;
                if (we) begin
                    rd_hold <= '0;
                end else begin
                    case (region)
                        region_ppu:  rd_hold <= ppu_data;
                        region_ctlr: rd_hold <= ctlr_data;
                        default:     rd_hold <= '0;
                    endcase
                end
            end
        end
    end

    // RAM output is already registered on the access edge
    assign dat_r = (rd_region == region_ram) ? ram_rdata : rd_hold;

    // Master keeps stb up until it has seen ack
    a_stb_until_ack : assert property (@(posedge clock) disable iff (!reset_n)
        $fell(stb) |-> ack)
        else $error("strobe dropped before acknowledge");

endmodule : wb_cpu_port

// File: logic/cpu_addr_decode.sv
module cpu_addr_decode (
    input  nes_bus_pkg::addr_t    acc_addr,
    output nes_bus_pkg::region_t  region,
    output nes_bus_pkg::ppu_sel_t ppu_sel
);

    import nes_bus_pkg::*;

    logic ram_mirror;
    logic ppu_mirror;
    logic dma_hit;
    logic ctlr_hit;

    // 0x0000-0x1FFF
    assign ram_mirror = (acc_addr[15:13] == 3'b000);
    // 0x2000-0x3FFF
    assign ppu_mirror = (acc_addr[15:13] == 3'b001);
    assign dma_hit    = (acc_addr == oam_dma_addr);
    assign ctlr_hit   = (acc_addr == ctlr_port1_addr) || (acc_addr == ctlr_port2_addr);

    always_comb begin
        region  = region_none;
        // Register index repeats every 8 bytes
        ppu_sel = ppu_sel_t'({1'b0, acc_addr[2:0]});
        if (ram_mirror) begin
            region = region_ram;
        end else if (ppu_mirror) begin
            region = region_ppu;
        end else if (dma_hit) begin
            region  = region_ppu;
            ppu_sel = oam_dma;
        end else if (ctlr_hit) begin
            region = region_ctlr;
        end
    end

endmodule : cpu_addr_decode

// File: logic/work_ram.sv
module work_ram #(
    parameter int ram_addr_bits = 11
) (
    input  logic               clock,
    input  logic               access,
    input  logic               ram_sel,
    input  logic               acc_we,
    input  nes_bus_pkg::addr_t acc_addr,
    input  nes_bus_pkg::data_t acc_wdata,
    output nes_bus_pkg::data_t ram_rdata
);

    import nes_bus_pkg::*;

    localparam int depth = 1 << ram_addr_bits;

    data_t mem [0:depth-1];

    logic [ram_addr_bits-1:0] ram_addr;

    // Upper address bits ignored, which mirrors the array
    assign ram_addr = acc_addr[ram_addr_bits-1:0];

    always_ff @(posedge clock) begin
        if (access && ram_sel && acc_we) begin
            mem[ram_addr] <= acc_wdata;
        end
        // Read every cycle, old data on a write
        ram_rdata <= mem[ram_addr];
    end

endmodule : work_ram

// File: logic/ppu_reg_port.sv
module ppu_reg_port (
    input  logic                  access,
    input  logic                  ppu_hit,
    input  logic                  acc_we,
    input  nes_bus_pkg::ppu_sel_t ppu_sel_in,
    input  nes_bus_pkg::data_t    acc_wdata,
    output logic                  ppu_en,
    output logic                  ppu_we,
    output nes_bus_pkg::ppu_sel_t ppu_sel,
    output nes_bus_pkg::data_t    ppu_wdata,
    input  nes_bus_pkg::data_t    ppu_rdata,
    output nes_bus_pkg::data_t    ppu_data
);

    import nes_bus_pkg::*;

    logic ppu_rd;
    logic dma_sel;

    // Strobe only in the access cycle
    assign ppu_en  = access && ppu_hit;
    assign ppu_we  = ppu_en && acc_we;
    assign ppu_rd  = ppu_en && !acc_we;
    assign ppu_sel = ppu_sel_in;
    assign dma_sel = (ppu_sel_in == oam_dma);

    // Write data bus stays quiet outside of writes
    assign ppu_wdata = ppu_we ? acc_wdata : '0;

    // Sprite DMA has no read side, reads give zero
    assign ppu_data = (ppu_rd && !dma_sel) ? ppu_rdata : '0;

    always_comb begin
        if (ppu_rd) begin
            assert (!dma_sel)
                else $error("read of write-only sprite DMA register");
        end
    end

endmodule : ppu_reg_port

// File: logic/ctlr_interface.sv
module ctlr_interface #(
    parameter int pulse_len = 3
) (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               access,
    input  logic               acc_we,
    input  nes_bus_pkg::addr_t acc_addr,
    input  nes_bus_pkg::data_t acc_wdata,
    input  logic               ctlr_data_p1,
    input  logic               ctlr_data_p2,
    output logic               ctlr_pulse_p1,
    output logic               ctlr_pulse_p2,
    output logic               ctlr_latch,
    output nes_bus_pkg::data_t ctlr_data
);

    import nes_bus_pkg::*;

    localparam int cnt_bits = (pulse_len > 1) ? $clog2(pulse_len) : 1;

    typedef enum logic {
        idle,
        pulsing
    } pulse_state_t;

    logic       port2_sel;
    logic       pad_bit;
    logic [1:0] rd_hit;
    logic [1:0] pulse_n;

    assign port2_sel = (acc_addr == ctlr_port2_addr);
    assign rd_hit[0] = access && !acc_we && (acc_addr == ctlr_port1_addr);
    assign rd_hit[1] = access && !acc_we && port2_sel;

    // Latch strobe lives in bit 0 of port 1
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ctlr_latch <= 1'b0;
        end else if (access && acc_we && (acc_addr == ctlr_port1_addr)) begin
            ctlr_latch <= acc_wdata[0];
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_port
        pulse_state_t        state;
        logic [cnt_bits-1:0] cnt;

        always_ff @(posedge clock or negedge reset_n) begin
            if (!reset_n) begin
                state <= idle;
                cnt   <= '0;
            end else begin
                case (state)
                    idle: begin
                        if (rd_hit[i]) begin
                            state <= pulsing;
                            cnt   <= cnt_bits'(pulse_len - 1);
                        end
                    end
                    // A read during a running pulse does not restart it
                    pulsing: begin
                        if (cnt == '0) begin
                            state <= idle;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end

        assign pulse_n[i] = (state != pulsing);

        a_pulse_len : assert property (@(posedge clock) disable iff (!reset_n)
            $fell(pulse_n[i]) |-> ##pulse_len $rose(pulse_n[i]))
            else $error("pad clock pulse width wrong on port %0d", i + 1);
    end

    assign ctlr_pulse_p1 = pulse_n[0];
    assign ctlr_pulse_p2 = pulse_n[1];

    // Pad data pins are active low
    assign pad_bit   = port2_sel ? ctlr_data_p2 : ctlr_data_p1;
    assign ctlr_data = {7'b0, ~pad_bit};

endmodule : ctlr_interface

// File: logic/cpu_memory_top.sv
module cpu_memory_top #(
    parameter int ram_addr_bits = 11,
    parameter int pulse_len     = 3
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  nes_bus_pkg::addr_t    adr,
    input  nes_bus_pkg::data_t    dat_w,
    output nes_bus_pkg::data_t    dat_r,
    output logic                  ack,
    output logic                  ppu_en,
    output nes_bus_pkg::ppu_sel_t ppu_sel,
    output logic                  ppu_we,
    output nes_bus_pkg::data_t    ppu_wdata,
    input  nes_bus_pkg::data_t    ppu_rdata,
    input  logic                  ctlr_data_p1,
    input  logic                  ctlr_data_p2,
    output logic                  ctlr_pulse_p1,
    output logic                  ctlr_pulse_p2,
    output logic                  ctlr_latch
);

    import nes_bus_pkg::*;

    logic     access;
    addr_t    acc_addr;
    logic     acc_we;
    data_t    acc_wdata;
    region_t  region;
    ppu_sel_t dec_ppu_sel;
    data_t    ram_rdata;
    data_t    ppu_data;
    data_t    ctlr_data;
    logic     ram_sel;
    logic     ppu_hit;

    assign ram_sel = (region == region_ram);
    assign ppu_hit = (region == region_ppu);

    wb_cpu_port i_port (
        .clock, .reset_n,
        .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .access, .acc_addr, .acc_we, .acc_wdata,
        .region, .ram_rdata, .ppu_data, .ctlr_data
    );

    cpu_addr_decode i_decode (
        .acc_addr,
        .region,
        .ppu_sel (dec_ppu_sel)
    );

    work_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) i_ram (
        .clock, .access, .ram_sel, .acc_we, .acc_addr, .acc_wdata, .ram_rdata
    );

    ppu_reg_port i_ppu (
        .access, .ppu_hit, .acc_we,
        .ppu_sel_in (dec_ppu_sel),
        .acc_wdata,
        .ppu_en, .ppu_we, .ppu_sel, .ppu_wdata, .ppu_rdata, .ppu_data
    );

    ctlr_interface #(
        .pulse_len (pulse_len)
    ) i_ctlr (
        .clock, .reset_n, .access, .acc_we, .acc_addr, .acc_wdata,
        .ctlr_data_p1, .ctlr_data_p2,
        .ctlr_pulse_p1, .ctlr_pulse_p2, .ctlr_latch,
        .ctlr_data
    );

endmodule : cpu_memory_top

// File: sim/tb_cpu_memory_tasks.svh
`ifndef TB_CPU_MEMORY_TASKS_SVH
`define TB_CPU_MEMORY_TASKS_SVH

task automatic stop_run(input string msg);
    $display("ERR @%0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "check failed");
endtask

task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
        stop_run($sformatf("%s got %02h expected %02h", what, got, exp));
    end
endtask

task automatic check_sel(input ppu_sel_t got, input ppu_sel_t exp, input string what);
    if (got !== exp) begin
        stop_run($sformatf("%s got %0d expected %0d", what, got, exp));
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        stop_run($sformatf("%s got %b expected %b", what, got, exp));
    end
endtask

// Drive a cycle on the falling edge
task automatic bus_start(input addr_t a, input logic w, input data_t d);
    @(negedge clock);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_w = d;
endtask

task automatic bus_finish(output data_t rdata);
    ack_cycles = 0;
    do begin
        @(negedge clock);
        ack_cycles++;
        if (ack_cycles > ack_limit) begin
            $display("No acknowledge from the DUT for address %04h", adr);
            $display("Test failed");
            $fatal(1, "bus timeout");
        end
    end while (!ack);
    rdata = dat_r;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
endtask

task automatic bus_write(input addr_t a, input data_t d);
    data_t dummy;
    bus_start(a, 1'b1, d);
    bus_finish(dummy);
endtask

task automatic bus_read(input addr_t a, output data_t d);
    bus_start(a, 1'b0, '0);
    bus_finish(d);
endtask

task automatic test_reset_state();
    check_bit(ack, 1'b0, "reset ack");
    check_bit(ppu_en, 1'b0, "reset ppu_en");
    check_bit(ctlr_latch, 1'b0, "reset ctlr_latch");
    check_bit(ctlr_pulse_p1, 1'b1, "reset pulse p1");
    check_bit(ctlr_pulse_p2, 1'b1, "reset pulse p2");
    check_data(dat_r, 8'h00, "reset dat_r");
endtask

task automatic test_work_ram();
    data_t  shadow [0:2047];
    addr_t  written [$];
    addr_t  a;
    data_t  d;
    data_t  got;
    int     pick;
    for (int i = 0; i < 40; i++) begin
        a = addr_t'($urandom % 16'h2000);
        d = data_t'($urandom);
        bus_write(a, d);
        shadow[a[10:0]] = d;
        written.push_back(a);
        // Read back through a random mirror of an earlier address
        pick = $urandom % written.size();
        a = written[pick];
        a = {3'b000, 2'($urandom), a[10:0]};
        bus_read(a, got);
        check_data(got, shadow[a[10:0]], $sformatf("RAM read %04h", a));
    end
endtask

task automatic test_ppu_port();
    data_t expect_regs [0:7];
    addr_t a;
    data_t d;
    data_t got;
    for (int n = 0; n < 8; n++) begin
        a = 16'h2000 + 16'(8 * ($urandom % 1024)) + 16'(n);
        d = data_t'($urandom);
        expect_regs[n] = d;
        bus_start(a, 1'b1, d);
        #1;
        check_bit(ppu_en, 1'b1, "ppu_en on write");
        check_bit(ppu_we, 1'b1, "ppu_we on write");
        check_sel(ppu_sel, ppu_sel_t'(n), "ppu_sel on write");
        check_data(ppu_wdata, d, "ppu_wdata");
        bus_finish(got);
        check_bit(ppu_en, 1'b0, "ppu_en after access");
    end
    for (int n = 0; n < 8; n++) begin
        a = 16'h2000 + 16'(8 * ($urandom % 1024)) + 16'(n);
        bus_start(a, 1'b0, '0);
        #1;
        check_bit(ppu_en, 1'b1, "ppu_en on read");
        check_bit(ppu_we, 1'b0, "ppu_we on read");
        check_sel(ppu_sel, ppu_sel_t'(n), "ppu_sel on read");
        bus_finish(got);
        check_data(got, expect_regs[n], $sformatf("PPU read %04h", a));
    end
    bus_start(16'h4014, 1'b1, 8'h02);
    #1;
    check_bit(ppu_en, 1'b1, "ppu_en on sprite DMA");
    check_sel(ppu_sel, oam_dma, "sprite DMA select");
    bus_finish(got);
endtask

task automatic read_pad_bit(input int port, input data_t buttons, input int idx);
    data_t got;
    int    width;
    bus_read(port == 1 ? ctlr_port1_addr : ctlr_port2_addr, got);
    check_data(got, {7'b0, buttons[idx]}, $sformatf("pad %0d bit %0d", port, idx));
    width = 0;
    while (!(port == 1 ? ctlr_pulse_p1 : ctlr_pulse_p2)) begin
        width++;
        if (width > pulse_len + 4) begin
            stop_run($sformatf("pad %0d pulse never ended", port));
        end
        @(negedge clock);
    end
    check_data(data_t'(width), data_t'(pulse_len), "pulse width");
endtask

task automatic test_controllers();
    pad1_buttons = data_t'($urandom);
    pad2_buttons = data_t'($urandom);
    bus_write(ctlr_port1_addr, 8'h01);
    check_bit(ctlr_latch, 1'b1, "latch set");
    bus_write(ctlr_port1_addr, 8'h00);
    check_bit(ctlr_latch, 1'b0, "latch clear");
    for (int i = 0; i < 8; i++) begin
        read_pad_bit(1, pad1_buttons, i);
    end
    // Pad 2 has not shifted yet
    for (int i = 0; i < 8; i++) begin
        read_pad_bit(2, pad2_buttons, i);
    end
endtask

task automatic test_unmapped();
    addr_t a;
    data_t got;
    for (int i = 0; i < 6; i++) begin
        a = (i % 2 == 0) ? 16'h4020 + 16'($urandom % 16'hBFE0) : 16'h4000 + 16'($urandom % 20);
        bus_write(a, data_t'($urandom));
        check_data(data_t'(ack_cycles), 8'd1, "write ack latency");
        bus_read(a, got);
        check_data(data_t'(ack_cycles), 8'd1, "read ack latency");
        check_data(got, 8'h00, $sformatf("unmapped read %04h", a));
    end
endtask

`endif

// File: sim/tb_cpu_memory.sv
module tb_cpu_memory;

    import nes_bus_pkg::*;

    localparam int clk_period    = 40;
    localparam int ram_addr_bits = 11;
    localparam int pulse_len     = 3;
    // Bus accesses of the RAM, PPU, pad and unmapped tests
    localparam int n_accesses    = 80 + 17 + 18 + 12;
    localparam int ack_limit     = 8;

    logic     clock;
    logic     reset_n;
    logic     cyc;
    logic     stb;
    logic     we;
    addr_t    adr;
    data_t    dat_w;
    data_t    dat_r;
    logic     ack;
    logic     ppu_en;
    ppu_sel_t ppu_sel;
    logic     ppu_we;
    data_t    ppu_wdata;
    data_t    ppu_rdata;
    logic     ctlr_data_p1;
    logic     ctlr_data_p2;
    logic     ctlr_pulse_p1;
    logic     ctlr_pulse_p2;
    logic     ctlr_latch;

    // Picture-processor model
    data_t ppu_regs [0:7];

    // Pad models
    data_t pad1_buttons;
    data_t pad2_buttons;
    data_t pad1_sr;
    data_t pad2_sr;
    logic  pulse_p1_q;
    logic  pulse_p2_q;

    // Cycles from bus_start to the sampled ack
    int    ack_cycles;

    cpu_memory_top #(
        .ram_addr_bits (ram_addr_bits),
        .pulse_len     (pulse_len)
    ) i_dut (
        .clock, .reset_n,
        .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .ppu_en, .ppu_sel, .ppu_we, .ppu_wdata, .ppu_rdata,
        .ctlr_data_p1, .ctlr_data_p2,
        .ctlr_pulse_p1, .ctlr_pulse_p2, .ctlr_latch
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // Answers within the access cycle
    assign ppu_rdata = ppu_regs[ppu_sel[2:0]];

    always @(posedge clock) begin
        if (ppu_en && ppu_we && ppu_sel < 4'd8) begin
            ppu_regs[ppu_sel[2:0]] <= ppu_wdata;
        end
    end

    // Load while latched, shift one edge after the pulse pin rises
    always @(posedge clock) begin
        pulse_p1_q <= ctlr_pulse_p1;
        pulse_p2_q <= ctlr_pulse_p2;
        if (ctlr_latch) begin
            pad1_sr <= pad1_buttons;
            pad2_sr <= pad2_buttons;
        end else begin
            if (ctlr_pulse_p1 && !pulse_p1_q) begin
                pad1_sr <= {1'b1, pad1_sr[7:1]};
            end
            if (ctlr_pulse_p2 && !pulse_p2_q) begin
                pad2_sr <= {1'b1, pad2_sr[7:1]};
            end
        end
    end

    // Pressed button pulls the pin low
    assign ctlr_data_p1 = ~pad1_sr[0];
    assign ctlr_data_p2 = ~pad2_sr[0];

    `include "tb_cpu_memory_tasks.svh"

    initial begin
        #(n_accesses * 10 * clk_period);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failed");
        $fatal(1, "simulation timeout");
    end

    initial begin
        void'($urandom(13298));
        reset_n      = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        pad1_buttons = '0;
        pad2_buttons = '0;
        pad1_sr      = '1;
        pad2_sr      = '1;
        pulse_p1_q   = 1'b1;
        pulse_p2_q   = 1'b1;
        ack_cycles   = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        test_reset_state();
        test_work_ram();
        test_ppu_port();
        test_controllers();
        test_unmapped();

        $display("Test passed");
        $finish;
    end

endmodule : tb_cpu_memory

// File: files.f
+incdir+sim
logic/nes_bus_pkg.sv
logic/wb_cpu_port.sv
logic/cpu_addr_decode.sv
logic/work_ram.sv
logic/ppu_reg_port.sv
logic/ctlr_interface.sv
logic/cpu_memory_top.sv
sim/tb_cpu_memory.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_cpu_memory -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
